// File: Makefile
# Verilator build and run of the FMA unit testbench

VERILATOR ?= verilator
TOP       ?= fma_unit_tb
FILELIST  ?= fma_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: fma_unit.f
+incdir+hw
hw/fma_pkg.sv
hw/fp16_unpack.sv
hw/booth_partial_product.sv
hw/digit_counter.sv
hw/fma_control.sv
hw/fma_datapath.sv
hw/fma_unit.sv
tests/fma_unit_tb.sv

// File: hw/booth_partial_product.sv
// radix-8 Booth partial product of the a-mantissa for one 4-bit window of the b-mantissa
`timescale 1ns/10ps
`default_nettype none

module booth_partial_product (
        input  logic [10:0]        mant_a,
        input  logic [3:0]         digit_bits,
        output logic signed [14:0] pp
);

        logic [14:0] mult_one;
        logic [14:0] mult_two;
        logic [14:0] mult_three;
        logic [14:0] mult_four;
        logic [14:0] magnitude;
        logic        negate;

        // zero-extended multiples, x3 is the only one needing an adder
        assign mult_one   = {4'b0, mant_a};
        assign mult_two   = {3'b0, mant_a, 1'b0};
        assign mult_three = mult_one + mult_two;
        assign mult_four  = {2'b0, mant_a, 2'b0};

        // digit = -4*w3 + 2*w2 + w1 + w0
        always_comb begin
                magnitude = '0;
                negate    = 1'b0;
                case (digit_bits)
                        4'b0001, 4'b0010: magnitude = mult_one;
                        4'b0011, 4'b0100: magnitude = mult_two;
                        4'b0101, 4'b0110: magnitude = mult_three;
                        4'b0111:          magnitude = mult_four;
                        4'b1000: begin
                                magnitude = mult_four;
                                negate    = 1'b1;
                        end
                        4'b1001, 4'b1010: begin
                                magnitude = mult_three;
                                negate    = 1'b1;
                        end
                        4'b1011, 4'b1100: begin
                                magnitude = mult_two;
                                negate    = 1'b1;
                        end
                        4'b1101, 4'b1110: begin
                                magnitude = mult_one;
                                negate    = 1'b1;
                        end
                        default:          magnitude = '0;
                endcase
        end

        // two's complement of the selected multiple
        assign pp = negate ? $signed(~magnitude + 15'd1) : $signed(magnitude);

        // the top window of b is zero-padded, so it may never produce a negative term
        always_comb begin
                assert final (digit_bits[3] || !pp[14])
                        else $error("booth: positive window gave negative partial product");
        end

endmodule

`default_nettype wire

// File: hw/digit_counter.sv
// counts the radix-8 Booth digit position during the multiply phase of the FMA
`timescale 1ns/10ps
`default_nettype none
`include "fma_config.svh"

module digit_counter (
        input  logic       clk,
        input  logic       arst_n,
        input  logic       clear,
        input  logic       step,
        output logic [1:0] digit,
        output logic       last
);

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        digit <= '0;
                end else if (clear) begin
                        digit <= '0;
                end else if (step) begin
                        digit <= digit + 2'd1;
                end
        end

        // final digit position reached
        assign last = (digit == 2'(`FMA_DIGITS - 1));

        // stepping past the last digit would wrap onto digit 0
        assert property (@(posedge clk) disable iff (!arst_n) !(step && last && !clear))
                else $error("digit_counter: step past last digit");

endmodule

`default_nettype wire

// File: hw/fma_config.svh
// fixed-point accumulator and Booth digit constants, included by the datapath, counter and testbench
`ifndef FMA_CONFIG_SVH
`define FMA_CONFIG_SVH

// signed fixed-point accumulator width
`define FMA_ACC_WIDTH 84

// accumulator lsb weighs 2**-48
`define FMA_FRAC_BITS 48

// radix-8 digits covering an 11-bit mantissa
`define FMA_DIGITS 4

`endif

// File: hw/fma_control.sv
// FSM sequencing load, Booth multiply, addend, normalize and the req/ack handshake
`timescale 1ns/10ps
`default_nettype none

module fma_control (
        input  logic clk,
        input  logic arst_n,
        input  logic req,
        input  logic last,
        output logic ack,
        output logic load,
        output logic mult_en,
        output logic add_en,
        output logic norm_en,
        output logic cnt_clear,
        output logic cnt_step
);
        import fma_pkg::*;

        fma_state_e state;
        fma_state_e state_next;

        always_comb begin
                state_next = state;
                case (state)
                        st_idle: begin
                                if (req && !ack) begin
                                        state_next = st_load;
                                end
                        end
                        st_load: state_next = st_mult;
                        st_mult: begin
                                // digit 3 is the last partial product
                                if (last) begin
                                        state_next = st_add;
                                end
                        end
                        st_add:  state_next = st_norm;
                        st_norm: state_next = st_done;
                        st_done: begin
                                // wait for the source to release req
                                if (ack && !req) begin
                                        state_next = st_idle;
                                end
                        end
                        default: state_next = st_idle;
                endcase
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        state <= st_idle;
                        ack   <= 1'b0;
                end else begin
                        state <= state_next;
                        // one cycle into st_done, held until req drops
                        ack   <= (state == st_done) && (state_next == st_done);
                end
        end

        assign load      = (state == st_load);
        assign mult_en   = (state == st_mult);
        assign add_en    = (state == st_add);
        assign norm_en   = (state == st_norm);
        assign cnt_clear = (state == st_load);
        assign cnt_step  = (state == st_mult) && !last;

        assert property (@(posedge clk) disable iff (!arst_n) ack |-> state == st_done)
                else $error("fma_control: ack outside st_done");

        assert property (@(posedge clk) disable iff (!arst_n)
                        $onehot0({load, mult_en, add_en, norm_en}))
                else $error("fma_control: datapath strobes overlap");

endmodule

`default_nettype wire

// File: hw/fma_datapath.sv
// FMA datapath holding operands and the exact fixed-point accumulator, then normalizing to FP16
`timescale 1ns/10ps
`default_nettype none
`include "fma_config.svh"

module fma_datapath (
        input  logic             clk,
        input  logic             arst_n,
        input  logic             load,
        input  logic             mult_en,
        input  logic             add_en,
        input  logic             norm_en,
        input  logic [1:0]       digit,
        input  fma_pkg::fma_op_e op,
        input  fma_pkg::fp16_t   a,
        input  fma_pkg::fp16_t   b,
        input  fma_pkg::fp16_t   c,
        output fma_pkg::fp16_t   result
);
        import fma_pkg::*;

        localparam int ACC_W    = `FMA_ACC_WIDTH;
        localparam int PROD_OFS = `FMA_FRAC_BITS - 20;
        localparam int ADD_OFS  = `FMA_FRAC_BITS - 10;
        localparam int EXP_HI   = `FMA_FRAC_BITS + 15;
        localparam int DEN_LIM  = `FMA_FRAC_BITS - 14;
        localparam int BIAS_POS = `FMA_FRAC_BITS - 15;

        logic                    u_sign_ab, u_sign_c;
        logic signed [5:0]       u_exp_a, u_exp_b, u_exp_c;
        logic [10:0]             u_mant_a, u_mant_b, u_mant_c;
        logic                    sign_ab_q, sign_c_q;
        logic signed [5:0]       exp_a_q, exp_b_q, exp_c_q;
        logic [10:0]             mant_a_q, mant_b_q, mant_c_q;
        fma_op_e                 op_q;
        logic [3:0]              window;
        logic signed [14:0]      pp;
        logic signed [ACC_W-1:0] pp_ext;
        logic signed [6:0]       prod_exp, c_exp;
        logic [6:0]              pp_shift;
        logic signed [ACC_W-1:0] acc;
        logic signed [ACC_W-1:0] addend;
        logic                    c_neg;
        logic [ACC_W-1:0]        mag, norm_shifted;
        logic [6:0]              lead_pos, norm_shift, exp_field;
        fp16_t                   res_next;

        fp16_unpack u_unpack (
                .a       (a),
                .b       (b),
                .c       (c),
                .sign_ab (u_sign_ab),
                .exp_a   (u_exp_a),
                .exp_b   (u_exp_b),
                .exp_c   (u_exp_c),
                .mant_a  (u_mant_a),
                .mant_b  (u_mant_b),
                .mant_c  (u_mant_c),
                .sign_c  (u_sign_c)
        );

        always_ff @(posedge clk) begin
                if (load) begin
                        sign_ab_q <= u_sign_ab;
                        sign_c_q  <= u_sign_c;
                        exp_a_q   <= u_exp_a;
                        exp_b_q   <= u_exp_b;
                        exp_c_q   <= u_exp_c;
                        mant_a_q  <= u_mant_a;
                        mant_b_q  <= u_mant_b;
                        mant_c_q  <= u_mant_c;
                        op_q      <= op;
                end
        end

        // overlapping windows of b, one per digit
        always_comb begin
                case (digit)
                        2'd0:    window = {mant_b_q[2:0], 1'b0};
                        2'd1:    window = mant_b_q[5:2];
                        2'd2:    window = mant_b_q[8:5];
                        default: window = {1'b0, mant_b_q[10:8]};
                endcase
        end

        booth_partial_product u_booth (
                .mant_a     (mant_a_q),
                .digit_bits (window),
                .pp         (pp)
        );

        assign pp_ext   = {{(ACC_W - 15){pp[14]}}, pp};
        assign prod_exp = exp_a_q + exp_b_q + 7'(PROD_OFS);
        // digit k sits 3k bits above the product alignment
        assign pp_shift = $unsigned(prod_exp) + {4'd0, digit, 1'b0} + {5'd0, digit};

        assign c_exp  = exp_c_q + 7'(ADD_OFS);
        assign addend = {{(ACC_W - 11){1'b0}}, mant_c_q} << $unsigned(c_exp);
        assign c_neg  = sign_c_q ^ (op_q == op_fms);

        always_ff @(posedge clk) begin
                if (load) begin
                        acc <= '0;
                end else if (mult_en) begin
                        acc <= sign_ab_q ? acc - (pp_ext <<< pp_shift)
                                         : acc + (pp_ext <<< pp_shift);
                end else if (add_en && op_q != op_mul) begin
                        acc <= c_neg ? acc - addend : acc + addend;
                end
        end

        assign mag = acc[ACC_W-1] ? $unsigned(-acc) : $unsigned(acc);

        // leading one search, highest set bit wins
        always_comb begin
                lead_pos = '0;
                for (int i = 0; i < ACC_W; i++) begin
                        if (mag[i]) begin
                                lead_pos = 7'(i);
                        end
                end
        end

        assign norm_shift   = lead_pos - 7'd10;
        assign norm_shifted = mag >> norm_shift;
        assign exp_field    = lead_pos - 7'(BIAS_POS);

        always_comb begin
                // exact zero stays +0
                res_next = '0;
                if (mag != '0) begin
                        res_next.sign = acc[ACC_W-1];
                        if (lead_pos > 7'(EXP_HI)) begin
                                // round toward zero saturates at max finite
                                res_next.exponent = 5'd30;
                                res_next.fraction = 10'h3ff;
                        end else if (lead_pos < 7'(DEN_LIM)) begin
                                res_next.exponent = 5'd0;
                                res_next.fraction = mag[BIAS_POS:BIAS_POS-9];
                        end else begin
                                res_next.exponent = exp_field[4:0];
                                res_next.fraction = norm_shifted[9:0];
                        end
                end
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        result <= '0;
                end else if (norm_en) begin
                        result <= res_next;
                end
        end

endmodule

`default_nettype wire

// File: hw/fma_pkg.sv
// shared FP16 word, opcode and FSM state types that the FMA RTL and testbench import
`default_nettype none

package fma_pkg;

        // half precision word of sign, biased exponent and fraction
        typedef struct packed {
                logic       sign;
                logic [4:0] exponent;
                logic [9:0] fraction;
        } fp16_t;

        // a*b+c, a*b-c or a*b
        typedef enum logic [1:0] {
                op_fma,
                op_fms,
                op_mul
        } fma_op_e;

        typedef enum logic [2:0] {
                st_idle,
                st_load,
                st_mult,
                st_add,
                st_norm,
                st_done
        } fma_state_e;

endpackage

`default_nettype wire

// File: hw/fma_unit.sv
// top level of the FP16 FMA unit, joining the FSM, digit counter and datapath
`timescale 1ns/10ps
`default_nettype none

module fma_unit (
        input  logic             clk,
        input  logic             arst_n,
        input  logic             req,
        input  fma_pkg::fma_op_e op,
        input  fma_pkg::fp16_t   a,
        input  fma_pkg::fp16_t   b,
        input  fma_pkg::fp16_t   c,
        output logic             ack,
        output fma_pkg::fp16_t   result
);

        logic       load;
        logic       mult_en;
        logic       add_en;
        logic       norm_en;
        logic       cnt_clear;
        logic       cnt_step;
        logic [1:0] digit;
        logic       last;

        fma_control u_control (
                .clk       (clk),
                .arst_n    (arst_n),
                .req       (req),
                .last      (last),
                .ack       (ack),
                .load      (load),
                .mult_en   (mult_en),
                .add_en    (add_en),
                .norm_en   (norm_en),
                .cnt_clear (cnt_clear),
                .cnt_step  (cnt_step)
        );

        digit_counter u_counter (
                .clk    (clk),
                .arst_n (arst_n),
                .clear  (cnt_clear),
                .step   (cnt_step),
                .digit  (digit),
                .last   (last)
        );

        fma_datapath u_datapath (
                .clk     (clk),
                .arst_n  (arst_n),
                .load    (load),
                .mult_en (mult_en),
                .add_en  (add_en),
                .norm_en (norm_en),
                .digit   (digit),
                .op      (op),
                .a       (a),
                .b       (b),
                .c       (c),
                .result  (result)
        );

endmodule

`default_nettype wire

// File: hw/fp16_unpack.sv
// combinational split of the three FP16 operands into sign, true exponent and full mantissa
`timescale 1ns/10ps
`default_nettype none

module fp16_unpack (
        input  fma_pkg::fp16_t     a,
        input  fma_pkg::fp16_t     b,
        input  fma_pkg::fp16_t     c,
        output logic               sign_ab,
        output logic signed [5:0]  exp_a,
        output logic signed [5:0]  exp_b,
        output logic signed [5:0]  exp_c,
        output logic [10:0]        mant_a,
        output logic [10:0]        mant_b,
        output logic [10:0]        mant_c,
        output logic               sign_c
);

        // denormals share the smallest normal exponent
        function automatic logic signed [5:0] true_exp(input logic [4:0] field);
                if (field == 5'd0) begin
                        return -6'sd14;
                end
                return $signed({1'b0, field}) - 6'sd15;
        endfunction

        // hidden bit only for normal numbers
        function automatic logic [10:0] full_mant(input logic [4:0] field,
                                                  input logic [9:0] frac);
                return {(field != 5'd0), frac};
        endfunction

        assign exp_a = true_exp(a.exponent);
        assign exp_b = true_exp(b.exponent);
        assign exp_c = true_exp(c.exponent);

        assign mant_a = full_mant(a.exponent, a.fraction);
        assign mant_b = full_mant(b.exponent, b.fraction);
        assign mant_c = full_mant(c.exponent, c.fraction);

        assign sign_ab = a.sign ^ b.sign;
        assign sign_c  = c.sign;

endmodule

`default_nettype wire

// File: tests/fma_unit_tb.sv
// table-driven testbench for the FP16 FMA unit that runs as top module fma_unit_tb
`timescale 1ns/10ps
`default_nettype none
`include "fma_config.svh"

module fma_unit_tb;
        import fma_pkg::*;

        localparam int CLK_PERIOD = 8;
        localparam int ACC_W      = `FMA_ACC_WIDTH;
        localparam int FRAC_BITS  = `FMA_FRAC_BITS;
        // a mantissa product carries 20 fraction bits and an addend 10
        localparam int PROD_OFS   = FRAC_BITS - 20;
        localparam int ADD_OFS    = FRAC_BITS - 10;
        localparam int LATENCY    = 8;
        localparam int ACK_LIMIT  = 16;
        localparam int N_RANDOM   = 40;

        typedef struct packed {
                fma_op_e op;
                fp16_t   a;
                fp16_t   b;
                fp16_t   c;
                fp16_t   expected;
        } vector_t;

        logic    clk;
        logic    arst_n;
        logic    req;
        fma_op_e op;
        fp16_t   a;
        fp16_t   b;
        fp16_t   c;
        logic    ack;
        fp16_t   result;

        vector_t vectors[$];
        integer  seed;
        logic    table_ready;
        int      errors;
        int      checks;
        int      entry;

        fma_unit uut (
                .clk    (clk),
                .arst_n (arst_n),
                .req    (req),
                .op     (op),
                .a      (a),
                .b      (b),
                .c      (c),
                .ack    (ack),
                .result (result)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        task automatic check_result(input fp16_t got, input fp16_t expected, input string name);
                checks++;
                if (got !== expected) begin
                        errors++;
                        $display("error at %0t: %s = %h, expected %h (entry %0d)",
                                 $time, name, got, expected, entry);
                end
        endtask

        task automatic check_latency(input int got, input int expected);
                checks++;
                if (got != expected) begin
                        errors++;
                        $display("error at %0t: latency = %0d, expected %0d (entry %0d)",
                                 $time, got, expected, entry);
                end
        endtask

        task automatic check_level(input logic got, input logic expected, input string name);
                checks++;
                if (got !== expected) begin
                        errors++;
                        $display("error at %0t: %s = %b, expected %b (entry %0d)",
                                 $time, name, got, expected, entry);
                end
        endtask

        // zero exponent field behaves like the smallest normal
        function automatic int operand_exp(input fp16_t v);
                if (v.exponent == 5'd0) begin
                        return -14;
                end
                return int'(v.exponent) - 15;
        endfunction

        function automatic logic [10:0] operand_mant(input fp16_t v);
                if (v.exponent == 5'd0) begin
                        return {1'b0, v.fraction};
                end
                return {1'b1, v.fraction};
        endfunction

        // exact fixed-point sum followed by one truncation to FP16
        function automatic fp16_t ref_fma(input fma_op_e vop, input fp16_t va,
                                          input fp16_t vb, input fp16_t vc);
                logic [21:0]      mant_prod;
                logic [ACC_W-1:0] prod;
                logic [ACC_W-1:0] addend;
                logic [ACC_W-1:0] sum;
                logic [ACC_W-1:0] mag;
                logic             neg_c;
                int               lead;
                int               e;
                int               i;
                fp16_t            r;
                mant_prod = {11'b0, operand_mant(va)} * {11'b0, operand_mant(vb)};
                prod = {{(ACC_W - 22){1'b0}}, mant_prod}
                       << (operand_exp(va) + operand_exp(vb) + PROD_OFS);
                addend = {{(ACC_W - 11){1'b0}}, operand_mant(vc)}
                         << (operand_exp(vc) + ADD_OFS);
                sum = '0;
                if (va.sign ^ vb.sign) begin
                        sum = sum - prod;
                end else begin
                        sum = sum + prod;
                end
                if (vop != op_mul) begin
                        neg_c = vc.sign ^ (vop == op_fms);
                        if (neg_c) begin
                                sum = sum - addend;
                        end else begin
                                sum = sum + addend;
                        end
                end
                if (sum == '0) begin
                        return '0;
                end
                r.sign = sum[ACC_W-1];
                mag = r.sign ? -sum : sum;
                lead = 0;
                for (i = 0; i < ACC_W; i++) begin
                        if (mag[i]) begin
                                lead = i;
                        end
                end
                e = lead - FRAC_BITS;
                if (e > 15) begin
                        r.exponent = 5'd30;
                        r.fraction = 10'h3ff;
                end else if (e < -14) begin
                        // denormal lsb weighs 2**-24
                        r.exponent = 5'd0;
                        r.fraction = 10'(mag >> (FRAC_BITS - 24));
                end else begin
                        r.exponent = 5'(e + 15);
                        r.fraction = 10'(mag >> (lead - 10));
                end
                return r;
        endfunction

        function automatic fp16_t random_operand();
                logic [31:0] r;
                fp16_t       v;
                r = $random(seed);
                v = r[15:0];
                // exponent field 31 is out of scope
                v.exponent = r[20:16] % 5'd31;
                return v;
        endfunction

        task automatic add_vector(input fma_op_e vop, input logic [15:0] va, input logic [15:0] vb,
                                  input logic [15:0] vc, input logic [15:0] vexp);
                vector_t v;
                v.op       = vop;
                v.a        = va;
                v.b        = vb;
                v.c        = vc;
                v.expected = vexp;
                vectors.push_back(v);
        endtask

        task automatic build_table();
                vector_t     v;
                logic [31:0] r;
                int          n;
                // exact sums and cancellation
                add_vector(op_fma, 16'h3e00, 16'h4000, 16'h3400, 16'h4280);
                add_vector(op_fms, 16'h3e00, 16'h4000, 16'h3400, 16'h4180);
                add_vector(op_mul, 16'h3e00, 16'h4000, 16'h3400, 16'h4200);
                add_vector(op_fma, 16'h3e00, 16'h4000, 16'hc200, 16'h0000);
                add_vector(op_fms, 16'h3e00, 16'h4000, 16'h4200, 16'h0000);
                add_vector(op_fma, 16'hbc00, 16'h3c00, 16'h3c00, 16'h0000);
                add_vector(op_mul, 16'h3e00, 16'h4000, 16'h7bff, 16'h4200);
                add_vector(op_fma, 16'h4100, 16'hbe00, 16'h3c00, 16'hc180);
                add_vector(op_fms, 16'h4100, 16'hbe00, 16'h3c00, 16'hc4c0);
                // negative Booth digits from dense b fractions
                add_vector(op_mul, 16'h3c00, 16'h3fff, 16'h0000, 16'h3fff);
                add_vector(op_mul, 16'h3e00, 16'h3fff, 16'h0000, 16'h41ff);
                add_vector(op_mul, 16'h3fff, 16'h3fff, 16'h0000, 16'h43fe);
                add_vector(op_mul, 16'h3c00, 16'h3d55, 16'h0000, 16'h3d55);
                // digits -1, -2 and -3 in windows 0 to 2, and -4 in each of them
                add_vector(op_mul, 16'h3c00, 16'h3db7, 16'h0000, 16'h3db7);
                add_vector(op_mul, 16'h3c00, 16'h3d6e, 16'h0000, 16'h3d6e);
                add_vector(op_mul, 16'h3e00, 16'h3d25, 16'h0000, 16'h3fb7);
                add_vector(op_mul, 16'h3c00, 16'h3d1c, 16'h0000, 16'h3d1c);
                add_vector(op_mul, 16'h3c00, 16'h3ee3, 16'h0000, 16'h3ee3);
                // saturation
                add_vector(op_fma, 16'h7bff, 16'h4000, 16'h0000, 16'h7bff);
                add_vector(op_mul, 16'hfbff, 16'h4000, 16'h0000, 16'hfbff);
                add_vector(op_mul, 16'h7800, 16'hc000, 16'h0000, 16'hfbff);
                add_vector(op_fma, 16'h7bff, 16'h3c00, 16'h7bff, 16'h7bff);
                // truncation toward zero
                add_vector(op_fma, 16'h3c00, 16'h3c00, 16'h1000, 16'h3c00);
                add_vector(op_fms, 16'h3c00, 16'h3c00, 16'h1000, 16'h3bff);
                add_vector(op_fma, 16'hbc00, 16'h3c00, 16'h9000, 16'hbc00);
                add_vector(op_fma, 16'h3c00, 16'h3c00, 16'h0001, 16'h3c00);
                // denormal inputs and results
                add_vector(op_mul, 16'h0001, 16'h3c00, 16'h0000, 16'h0001);
                add_vector(op_mul, 16'h0001, 16'h4000, 16'h0000, 16'h0002);
                add_vector(op_mul, 16'h0400, 16'h3800, 16'h0000, 16'h0200);
                add_vector(op_mul, 16'h0001, 16'h3800, 16'h0000, 16'h0000);
                add_vector(op_fma, 16'h0000, 16'h0000, 16'h03ff, 16'h03ff);
                add_vector(op_fma, 16'h0200, 16'h3c00, 16'h0200, 16'h0400);
                add_vector(op_fms, 16'h0200, 16'h3c00, 16'h0200, 16'h0000);
                for (n = 0; n < N_RANDOM; n++) begin
                        r          = $random(seed);
                        v.op       = fma_op_e'(2'(r % 32'd3));
                        v.a        = random_operand();
                        v.b        = random_operand();
                        v.c        = random_operand();
                        v.expected = ref_fma(v.op, v.a, v.b, v.c);
                        vectors.push_back(v);
                end
        endtask

        // one four-phase transaction that may hold req past ack
        task automatic run_entry(input vector_t v, input int hold);
                int cycles;
                int k;
                @(posedge clk);
                #1;
                op  = v.op;
                a   = v.a;
                b   = v.b;
                c   = v.c;
                req = 1'b1;
                // the idle unit samples req at this edge
                @(posedge clk);
                cycles = 0;
                @(negedge clk);
                while (!ack && cycles < ACK_LIMIT) begin
                        @(posedge clk);
                        cycles++;
                        @(negedge clk);
                end
                if (!ack) begin
                        errors++;
                        $display("entry %0d: no ack within %0d cycles of the request",
                                 entry, ACK_LIMIT);
                end else begin
                        check_latency(cycles, LATENCY);
                        check_result(result, v.expected, "result");
                end
                for (k = 0; k < hold; k++) begin
                        @(negedge clk);
                        check_level(ack, 1'b1, "ack");
                        check_result(result, v.expected, "result");
                end
                @(posedge clk);
                #1;
                req = 1'b0;
                cycles = 0;
                @(negedge clk);
                while (ack && cycles < 4) begin
                        @(negedge clk);
                        cycles++;
                end
                if (ack) begin
                        errors++;
                        $display("entry %0d: ack stayed high after req was dropped", entry);
                end
        endtask

        initial begin
                wait (table_ready);
                repeat (vectors.size() * 20 + 50) @(posedge clk);
                $display("timeout: the tests did not finish in time");
                $display("Simulation failed");
                $finish;
        end

        initial begin
                seed        = 32'hb59edf4d;
                errors      = 0;
                checks      = 0;
                entry       = -1;
                table_ready = 1'b0;
                arst_n      = 1'b0;
                req         = 1'b0;
                op          = op_fma;
                a           = '0;
                b           = '0;
                c           = '0;
                build_table();
                table_ready = 1'b1;
                repeat (8) @(posedge clk);
                #1;
                arst_n = 1'b1;
                @(negedge clk);
                check_level(ack, 1'b0, "ack");
                check_result(result, 16'h0000, "result");
                for (entry = 0; entry < vectors.size(); entry++) begin
                        run_entry(vectors[entry], (entry % 4 == 3) ? 3 : 0);
                end
                $display("checks: %0d, errors: %0d", checks, errors);
                if (errors == 0) begin
                        $display("Simulation passed");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

`default_nettype wire
